/* iq_defines.svh */
`ifndef IQ_DEFINES_SVH
`define IQ_DEFINES_SVH

// queue geometry
`define IQ_ENTRIES 8
`define IQ_WAYS    4

// physical register file, banked on the low register bits
`define PR_W     7
`define BANK_W   2
`define IQ_BANKS (1 << `BANK_W)

// reorder buffer index and operation code
`define ROB_W 7
`define OP_W  4

`endif

/* iq_pkg.sv */
`include "iq_defines.svh"

package iq_pkg;

    // operation as held in an entry
    typedef struct packed {
        logic [`OP_W-1:0]  op;
        logic [`PR_W-1:0]  a_pr;
        logic              a_ready;
        logic              a_is_zero;
        logic [`PR_W-1:0]  b_pr;
        logic              b_ready;
        logic              b_is_zero;
        logic [`PR_W-1:0]  dest_pr;
        logic [`ROB_W-1:0] rob_index;
    } iq_op_t;

    // one dispatch way
    typedef struct packed {
        logic   is_alu;
        logic   is_mdu;
        iq_op_t op;
    } iq_dispatch_t;

    // entry is valid when either kind bit is set
    typedef struct packed {
        logic   is_alu;
        logic   is_mdu;
        iq_op_t op;
    } iq_entry_t;

    // writeback bus, one lane per bank
    typedef struct packed {
        logic [`IQ_BANKS-1:0]                       valid;
        logic [`IQ_BANKS-1:0][`PR_W-`BANK_W-1:0]    upper;
    } wb_bus_t;

    // issue record plus register read requests
    typedef struct packed {
        logic              valid;
        logic [`OP_W-1:0]  op;
        logic              a_forward;
        logic              a_is_zero;
        logic [`BANK_W-1:0] a_bank;
        logic              b_forward;
        logic              b_is_zero;
        logic [`BANK_W-1:0] b_bank;
        logic [`PR_W-1:0]  dest_pr;
        logic [`ROB_W-1:0] rob_index;
        logic              prf_a_valid;
        logic [`PR_W-1:0]  prf_a_pr;
        logic              prf_b_valid;
        logic [`PR_W-1:0]  prf_b_pr;
    } iq_issue_t;

endpackage

/* iq_dispatch_router.sv */
`timescale 1ns/1ps
`include "iq_defines.svh"

module iq_dispatch_router
    import iq_pkg::*;
(
    input  logic         [`IQ_WAYS-1:0]    dispatch_attempt,
    input  iq_dispatch_t [`IQ_WAYS-1:0]    dispatch_op,
    input  logic         [`IQ_ENTRIES-1:0] free,
    output logic         [`IQ_WAYS-1:0]    dispatch_ack,
    output iq_dispatch_t [`IQ_ENTRIES-1:0] route_op,
    output logic         [`IQ_ENTRIES-1:0] route_take
);

    // one-hot entry pick per way
    logic [`IQ_WAYS-1:0][`IQ_ENTRIES-1:0] pick;

    // ------------------------------
    // cascaded lowest-free pick

    always_comb begin
        logic [`IQ_ENTRIES-1:0] open;
        logic [`IQ_ENTRIES-1:0] req;

        open = free;
        for (int w = 0; w < `IQ_WAYS; w++) begin
            req = open & {`IQ_ENTRIES{dispatch_attempt[w]}};
            // isolate lowest set bit
            pick[w] = req & (~req + 1'b1);
            dispatch_ack[w] = |req;
            // later ways only see what is left
            open = open & ~pick[w];
        end
    end

    // ------------------------------
    // way to entry crossbar

    always_comb begin
        route_op = '0;
        route_take = '0;
        for (int e = 0; e < `IQ_ENTRIES; e++) begin
            for (int w = 0; w < `IQ_WAYS; w++) begin
                if (pick[w][e]) begin
                    route_op[e] = route_op[e] | dispatch_op[w];
                    route_take[e] = 1'b1;
                end
            end
        end
    end

endmodule

/* iq_entry.sv */
`timescale 1ns/1ps
`include "iq_defines.svh"

module iq_entry
    import iq_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,
    input  iq_dispatch_t self_route,
    input  iq_dispatch_t up1_route,
    input  iq_dispatch_t up2_route,
    input  logic         self_take,
    input  logic         up1_take,
    input  logic         up2_take,
    input  iq_entry_t    up1_state,
    input  iq_entry_t    up2_state,
    input  logic [1:0]   up1_fwd,
    input  logic [1:0]   up2_fwd,
    input  logic         alu_mask_lo,
    input  logic         alu_mask_hi,
    input  logic         mdu_mask_lo,
    input  logic         mdu_mask_hi,
    input  wb_bus_t      wb_bus,
    output iq_entry_t    state,
    output logic         a_forward,
    output logic         b_forward,
    output logic         alu_req,
    output logic         mdu_req,
    output logic         free
);

    logic               is_alu_q;
    logic               is_mdu_q;
    iq_op_t             op_q;
    iq_entry_t          nxt;
    iq_entry_t          src_state;
    iq_dispatch_t       src_route;
    logic [1:0]         src_fwd;
    logic               src_take;
    logic [`BANK_W-1:0] a_bank;
    logic [`BANK_W-1:0] b_bank;

    assign state = '{is_alu: is_alu_q, is_mdu: is_mdu_q, op: op_q};
    assign free = ~(is_alu_q | is_mdu_q);

    // ------------------------------
    // wakeup against the operand's bank
    assign a_bank = op_q.a_pr[`BANK_W-1:0];
    assign b_bank = op_q.b_pr[`BANK_W-1:0];
    assign a_forward = wb_bus.valid[a_bank] & (wb_bus.upper[a_bank] == op_q.a_pr[`PR_W-1:`BANK_W]);
    assign b_forward = wb_bus.valid[b_bank] & (wb_bus.upper[b_bank] == op_q.b_pr[`PR_W-1:`BANK_W]);

    // zero register counts as ready
    assign alu_req = is_alu_q & (op_q.a_ready | a_forward | op_q.a_is_zero)
                              & (op_q.b_ready | b_forward | op_q.b_is_zero);
    assign mdu_req = is_mdu_q & (op_q.a_ready | a_forward | op_q.a_is_zero)
                              & (op_q.b_ready | b_forward | op_q.b_is_zero);

    // ------------------------------
    // collapse: two places when both ports issue at or below us
    always_comb begin
        if ((alu_mask_lo & mdu_mask_hi) | (alu_mask_hi & mdu_mask_lo)) begin
            src_state = up2_state;
            src_fwd = up2_fwd;
            src_route = up2_route;
            src_take = up2_take;
        end else if (alu_mask_lo | mdu_mask_lo) begin
            src_state = up1_state;
            src_fwd = up1_fwd;
            src_route = up1_route;
            src_take = up1_take;
        end else begin
            src_state = state;
            src_fwd = {b_forward, a_forward};
            src_route = self_route;
            src_take = self_take;
        end

        nxt = '0;
        if (src_state.is_alu | src_state.is_mdu) begin
            // stored op, latch any wakeup seen this cycle
            nxt = src_state;
            nxt.op.a_ready = src_state.op.a_ready | src_fwd[0];
            nxt.op.b_ready = src_state.op.b_ready | src_fwd[1];
        end else if (src_take) begin
            nxt.is_alu = src_route.is_alu;
            nxt.is_mdu = src_route.is_mdu;
            nxt.op = src_route.op;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            is_alu_q <= 1'b0;
            is_mdu_q <= 1'b0;
        end else begin
            is_alu_q <= nxt.is_alu;
            is_mdu_q <= nxt.is_mdu;
        end
    end

    always_ff @(posedge CLK) begin
        op_q <= nxt.op;
    end

endmodule

/* iq_issue_select.sv */
`timescale 1ns/1ps
`include "iq_defines.svh"

module iq_issue_select
    import iq_pkg::*;
(
    input  logic                         pipe_ready,
    input  logic      [`IQ_ENTRIES-1:0] req,
    input  iq_entry_t [`IQ_ENTRIES-1:0] entries,
    input  logic      [`IQ_ENTRIES-1:0] a_forward,
    input  logic      [`IQ_ENTRIES-1:0] b_forward,
    output iq_issue_t                    issue,
    output logic      [`IQ_ENTRIES-1:0] issue_mask
);

    logic      [`IQ_ENTRIES-1:0] gated;
    logic      [`IQ_ENTRIES-1:0] pick;
    logic                        any;
    iq_entry_t                   sel;
    logic                        sel_a_fwd;
    logic                        sel_b_fwd;

    // ------------------------------
    // oldest ready entry sits at the lowest index
    assign gated = req & {`IQ_ENTRIES{pipe_ready}};
    assign pick = gated & (~gated + 1'b1);
    assign any = |gated;

    // picked entry and everything above it
    assign issue_mask = ~(pick - 1'b1);

    // one-hot mux
    always_comb begin
        sel = '0;
        sel_a_fwd = 1'b0;
        sel_b_fwd = 1'b0;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            if (pick[i]) begin
                sel = sel | entries[i];
                sel_a_fwd = sel_a_fwd | a_forward[i];
                sel_b_fwd = sel_b_fwd | b_forward[i];
            end
        end
    end

    // ------------------------------
    // issue record
    assign issue.valid = any;
    assign issue.op = sel.op.op;
    assign issue.a_forward = sel_a_fwd;
    assign issue.a_is_zero = sel.op.a_is_zero;
    assign issue.a_bank = sel.op.a_pr[`BANK_W-1:0];
    assign issue.b_forward = sel_b_fwd;
    assign issue.b_is_zero = sel.op.b_is_zero;
    assign issue.b_bank = sel.op.b_pr[`BANK_W-1:0];
    assign issue.dest_pr = sel.op.dest_pr;
    assign issue.rob_index = sel.op.rob_index;

    // read the PRF only when the value is not bypassed or zero
    assign issue.prf_a_valid = any & ~sel_a_fwd & ~sel.op.a_is_zero;
    assign issue.prf_a_pr = sel.op.a_pr;
    assign issue.prf_b_valid = any & ~sel_b_fwd & ~sel.op.b_is_zero;
    assign issue.prf_b_pr = sel.op.b_pr;

endmodule

/* alu_reg_mdu_iq.sv */
`timescale 1ns/1ps
`include "iq_defines.svh"

module alu_reg_mdu_iq
    import iq_pkg::*;
(
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic         [`IQ_WAYS-1:0] dispatch_attempt,
    input  iq_dispatch_t [`IQ_WAYS-1:0] dispatch_op,
    output logic         [`IQ_WAYS-1:0] dispatch_ack,
    input  logic                         alu_reg_ready,
    input  logic                         mdu_ready,
    input  wb_bus_t                      wb_bus,
    output iq_issue_t                    issue_alu_reg,
    output iq_issue_t                    issue_mdu
);

    // padded two above the top so neighbours read as invalid
    iq_dispatch_t [`IQ_ENTRIES+1:0]      route_pad;
    logic         [`IQ_ENTRIES+1:0]      take_pad;
    iq_entry_t    [`IQ_ENTRIES+1:0]      state_pad;
    logic         [`IQ_ENTRIES+1:0][1:0] fwd_pad;
    logic         [`IQ_ENTRIES:0]        alu_mask_pad;
    logic         [`IQ_ENTRIES:0]        mdu_mask_pad;
    logic         [`IQ_ENTRIES-1:0]      free;
    logic         [`IQ_ENTRIES-1:0]      alu_req;
    logic         [`IQ_ENTRIES-1:0]      mdu_req;
    logic         [`IQ_ENTRIES-1:0]      a_forward;
    logic         [`IQ_ENTRIES-1:0]      b_forward;

    assign route_pad[`IQ_ENTRIES+1:`IQ_ENTRIES] = '0;
    assign take_pad[`IQ_ENTRIES+1:`IQ_ENTRIES] = '0;
    assign state_pad[`IQ_ENTRIES+1:`IQ_ENTRIES] = '0;
    assign fwd_pad[`IQ_ENTRIES+1:`IQ_ENTRIES] = '0;
    assign alu_mask_pad[`IQ_ENTRIES] = 1'b0;
    assign mdu_mask_pad[`IQ_ENTRIES] = 1'b0;

    iq_dispatch_router router_i (
        .dispatch_attempt(dispatch_attempt), .dispatch_op(dispatch_op), .free(free),
        .dispatch_ack(dispatch_ack), .route_op(route_pad[`IQ_ENTRIES-1:0]),
        .route_take(take_pad[`IQ_ENTRIES-1:0])
    );

    // ------------------------------
    // entry array, index 0 is oldest
    for (genvar i = 0; i < `IQ_ENTRIES; i++) begin : g_entry
        assign fwd_pad[i] = {b_forward[i], a_forward[i]};

        iq_entry entry_i (
            .CLK(CLK), .nRST(nRST),
            .self_route(route_pad[i]), .up1_route(route_pad[i+1]), .up2_route(route_pad[i+2]),
            .self_take(take_pad[i]), .up1_take(take_pad[i+1]), .up2_take(take_pad[i+2]),
            .up1_state(state_pad[i+1]), .up2_state(state_pad[i+2]),
            .up1_fwd(fwd_pad[i+1]), .up2_fwd(fwd_pad[i+2]),
            .alu_mask_lo(alu_mask_pad[i]), .alu_mask_hi(alu_mask_pad[i+1]),
            .mdu_mask_lo(mdu_mask_pad[i]), .mdu_mask_hi(mdu_mask_pad[i+1]),
            .wb_bus(wb_bus), .state(state_pad[i]),
            .a_forward(a_forward[i]), .b_forward(b_forward[i]),
            .alu_req(alu_req[i]), .mdu_req(mdu_req[i]), .free(free[i])
        );
    end

    iq_issue_select alu_sel_i (
        .pipe_ready(alu_reg_ready), .req(alu_req), .entries(state_pad[`IQ_ENTRIES-1:0]),
        .a_forward(a_forward), .b_forward(b_forward),
        .issue(issue_alu_reg), .issue_mask(alu_mask_pad[`IQ_ENTRIES-1:0])
    );

    iq_issue_select mdu_sel_i (
        .pipe_ready(mdu_ready), .req(mdu_req), .entries(state_pad[`IQ_ENTRIES-1:0]),
        .a_forward(a_forward), .b_forward(b_forward),
        .issue(issue_mdu), .issue_mask(mdu_mask_pad[`IQ_ENTRIES-1:0])
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // reset held for four rising edges
    initial begin
        nRST = 1'b0;
        repeat (4) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps
`include "iq_defines.svh"

module tb_checker
    import iq_pkg::*;
(
    input  logic                         CLK,
    input  logic                         check_en,
    input  logic         [3:0]           exp_ack,
    input  logic         [15:0]          exp_alu,
    input  logic         [15:0]          exp_mdu,
    input  logic         [`IQ_WAYS-1:0] dispatch_attempt,
    input  iq_dispatch_t [`IQ_WAYS-1:0] dispatch_op,
    input  logic         [`IQ_WAYS-1:0] dispatch_ack,
    input  iq_issue_t                    issue_alu_reg,
    input  iq_issue_t                    issue_mdu,
    output int                           mismatch_count,
    output int                           other_count
);

    // every dispatched op, looked up by rob index
    iq_dispatch_t op_table [0:(1<<`ROB_W)-1];
    logic         seen     [0:(1<<`ROB_W)-1];

    initial begin
        mismatch_count = 0;
        other_count = 0;
        for (int i = 0; i < (1 << `ROB_W); i++) begin
            seen[i] = 1'b0;
        end
    end

    // expected word: valid nibble, forward nibble {a, b}, rob byte
    function automatic iq_issue_t expected_issue(input logic [15:0] word, input iq_dispatch_t d);
        iq_issue_t e;
        e = '0;
        if (word[12]) begin
            e.valid = 1'b1;
            e.op = d.op.op;
            e.a_forward = word[9];
            e.a_is_zero = d.op.a_is_zero;
            e.a_bank = d.op.a_pr[`BANK_W-1:0];
            e.b_forward = word[8];
            e.b_is_zero = d.op.b_is_zero;
            e.b_bank = d.op.b_pr[`BANK_W-1:0];
            e.dest_pr = d.op.dest_pr;
            e.rob_index = d.op.rob_index;
            e.prf_a_valid = ~word[9] & ~d.op.a_is_zero;
            e.prf_a_pr = d.op.a_pr;
            e.prf_b_valid = ~word[8] & ~d.op.b_is_zero;
            e.prf_b_pr = d.op.b_pr;
        end
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
            mismatch_count++;
        end
    endtask

    task automatic check_issue(input string port, input logic [15:0] word, input iq_issue_t act);
        logic [`ROB_W-1:0] rob;
        rob = word[`ROB_W-1:0];
        if (word[12] && !seen[rob]) begin
            $display("%s should issue rob 0x%0h, but that op was never dispatched", port, rob);
            other_count++;
        end else begin
            compare_value(port, 64'(expected_issue(word, op_table[rob])), 64'(act));
        end
    endtask

    // ------------------------------
    // sample mid-cycle, inputs settled
    always @(negedge CLK) begin
        if (check_en) begin
            for (int w = 0; w < `IQ_WAYS; w++) begin
                if (dispatch_attempt[w]) begin
                    op_table[dispatch_op[w].op.rob_index] = dispatch_op[w];
                    seen[dispatch_op[w].op.rob_index] = 1'b1;
                end
            end
            compare_value("dispatch_ack", 64'(exp_ack), 64'(dispatch_ack));
            check_issue("issue_alu_reg", exp_alu, issue_alu_reg);
            check_issue("issue_mdu", exp_mdu, issue_mdu);
        end
    end

endmodule

/* alu_reg_mdu_iq_sva.sv */
`timescale 1ns/1ps
`include "iq_defines.svh"

module alu_reg_mdu_iq_sva
    import iq_pkg::*;
(
    input logic                  CLK,
    input logic                  nRST,
    input logic [`IQ_WAYS-1:0]  dispatch_attempt,
    input logic [`IQ_WAYS-1:0]  dispatch_ack,
    input logic                  alu_reg_ready,
    input logic                  mdu_ready,
    input iq_issue_t             issue_alu_reg,
    input iq_issue_t             issue_mdu
);

    ack_needs_attempt: assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_ack & ~dispatch_attempt) == '0)
        else $error("dispatch ack without attempt");

    alu_issue_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        issue_alu_reg.valid |-> alu_reg_ready)
        else $error("alu issue while pipeline not ready");

    mdu_issue_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        issue_mdu.valid |-> mdu_ready)
        else $error("mdu issue while pipeline not ready");

    // queue comes out of reset empty
    idle_after_reset: assert property (@(posedge CLK)
        !nRST |=> (!issue_alu_reg.valid && !issue_mdu.valid))
        else $error("issue valid right after reset");

endmodule

bind alu_reg_mdu_iq alu_reg_mdu_iq_sva sva_i (
    .CLK(CLK),
    .nRST(nRST),
    .dispatch_attempt(dispatch_attempt),
    .dispatch_ack(dispatch_ack),
    .alu_reg_ready(alu_reg_ready),
    .mdu_ready(mdu_ready),
    .issue_alu_reg(issue_alu_reg),
    .issue_mdu(issue_mdu)
);

/* tb_alu_reg_mdu_iq.sv */
`timescale 1ns/1ps
`include "iq_defines.svh"

module tb_alu_reg_mdu_iq
    import iq_pkg::*;
;

    localparam int WORDS_PER_LINE = 11;
    localparam int MAX_LINES = 32;
    localparam int RESET_LIMIT = 50;

    logic                         CLK;
    logic                         nRST;
    logic         [`IQ_WAYS-1:0] dispatch_attempt;
    iq_dispatch_t [`IQ_WAYS-1:0] dispatch_op;
    logic         [`IQ_WAYS-1:0] dispatch_ack;
    logic                         alu_reg_ready;
    logic                         mdu_ready;
    wb_bus_t                      wb_bus;
    iq_issue_t                    issue_alu_reg;
    iq_issue_t                    issue_mdu;

    logic        check_en;
    logic [3:0]  exp_ack;
    logic [15:0] exp_alu;
    logic [15:0] exp_mdu;
    int          mismatch_count;
    int          other_count;
    int          setup_errors;
    int          num_lines;
    int          wait_cycles;

    logic [39:0] pattern_mem [0:WORDS_PER_LINE*MAX_LINES-1];

    tb_clock_gen clock_i (.CLK(CLK), .nRST(nRST));

    alu_reg_mdu_iq alu_reg_mdu_iq_i (
        .CLK(CLK), .nRST(nRST),
        .dispatch_attempt(dispatch_attempt), .dispatch_op(dispatch_op),
        .dispatch_ack(dispatch_ack),
        .alu_reg_ready(alu_reg_ready), .mdu_ready(mdu_ready), .wb_bus(wb_bus),
        .issue_alu_reg(issue_alu_reg), .issue_mdu(issue_mdu)
    );

    tb_checker checker_i (
        .CLK(CLK), .check_en(check_en),
        .exp_ack(exp_ack), .exp_alu(exp_alu), .exp_mdu(exp_mdu),
        .dispatch_attempt(dispatch_attempt), .dispatch_op(dispatch_op),
        .dispatch_ack(dispatch_ack),
        .issue_alu_reg(issue_alu_reg), .issue_mdu(issue_mdu),
        .mismatch_count(mismatch_count), .other_count(other_count)
    );

    // way word holds kind, op, a_pr, b_pr, flags {a_rdy, a_zero, b_rdy, b_zero} and rob
    function automatic iq_dispatch_t decode_way(input logic [39:0] w);
        iq_dispatch_t d;
        d = '0;
        d.is_alu = w[33];
        d.is_mdu = w[32];
        d.op.op = w[31:28];
        d.op.a_pr = w[26:20];
        d.op.b_pr = w[18:12];
        d.op.a_ready = w[11];
        d.op.a_is_zero = w[10];
        d.op.b_ready = w[9];
        d.op.b_is_zero = w[8];
        d.op.rob_index = w[6:0];
        d.op.dest_pr = ~w[6:0];
        return d;
    endfunction

    task automatic apply_line(input int line);
        int base;
        base = line * WORDS_PER_LINE;
        dispatch_attempt = pattern_mem[base][3:0];
        for (int w = 0; w < `IQ_WAYS; w++) begin
            dispatch_op[w] = decode_way(pattern_mem[base+1+w]);
        end
        wb_bus.valid = pattern_mem[base+5][3:0];
        for (int b = 0; b < `IQ_BANKS; b++) begin
            wb_bus.upper[b] = pattern_mem[base+6][8*b +: (`PR_W-`BANK_W)];
        end
        alu_reg_ready = pattern_mem[base+7][1];
        mdu_ready = pattern_mem[base+7][0];
        exp_ack = pattern_mem[base+8][3:0];
        exp_alu = pattern_mem[base+9][15:0];
        exp_mdu = pattern_mem[base+10][15:0];
    endtask

    initial begin
        dispatch_attempt = '0;
        dispatch_op = '0;
        alu_reg_ready = 1'b0;
        mdu_ready = 1'b0;
        wb_bus = '0;
        check_en = 1'b0;
        exp_ack = '0;
        exp_alu = '0;
        exp_mdu = '0;
        setup_errors = 0;

        // marker in the top nibble flags words the file did not fill
        for (int a = 0; a < WORDS_PER_LINE * MAX_LINES; a++) begin
            pattern_mem[a] = {8'hE0, 32'(a)};
        end
        $readmemh("iq_patterns.hex", pattern_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES
               && pattern_mem[num_lines*WORDS_PER_LINE][39:36] != 4'hE) begin
            num_lines++;
        end

        wait_cycles = 0;
        while (nRST !== 1'b1 && wait_cycles < RESET_LIMIT) begin
            @(posedge CLK);
            wait_cycles++;
        end

        if (nRST !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_LIMIT);
            $display("Verification failed");
            $finish;
        end else begin
            if (num_lines == 0) begin
                $display("no stimulus lines found in iq_patterns.hex");
                setup_errors++;
            end
            for (int k = 0; k < num_lines; k++) begin
                @(posedge CLK);
                #1;
                apply_line(k);
                check_en = 1'b1;
            end
            @(posedge CLK);
            #1;
            check_en = 1'b0;
            $display("errors: %0d mismatches, %0d other", mismatch_count,
                     other_count + setup_errors);
            if (mismatch_count == 0 && other_count == 0 && setup_errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

/* alu_reg_mdu_iq.f */
+incdir+.
iq_pkg.sv
iq_dispatch_router.sv
iq_entry.sv
iq_issue_select.sv
alu_reg_mdu_iq.sv
tb_clock_gen.sv
tb_checker.sv
alu_reg_mdu_iq_sva.sv
tb_alu_reg_mdu_iq.sv

/* run_sim.sh */
#!/bin/sh
# build and run the issue queue testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal \
        --top-module tb_alu_reg_mdu_iq \
        -f alu_reg_mdu_iq.f \
        --Mdir obj_dir -o tb_sim > build.log 2>&1; then
    echo "build failed, see build.log"
    exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* iq_patterns.hex */
// att way0 way1 way2 way3 wb_valid wb_upper(lane3..0) ready{alu,mdu} exp_ack exp_alu exp_mdu
// way: kind op a_pr b_pr flags rob; issue: valid fwd{a,b} rob
0 0         0         0         0         0 00000000 0 0 0000 0000
f 210506a01 120708a02 23090aa03 140b0ca04 0 00000000 0 f 0000 0000
1 252d31205 0         0         0         0 00000000 0 1 0000 0000
f 26000e606 170f10a07 28112d808 291324a09 0 00000000 0 7 0000 0000
1 291324a09 0         0         0         0 00000000 0 0 0000 0000
1 291324a09 0         0         0         0 00000000 3 0 1001 1002
1 291324a09 0         0         0         0 00000000 3 1 1003 1004
1 1a1516a0a 0         0         0         2 00000b00 2 1 1205 0000
0 0         0         0         0         0 00000000 2 0 1006 0000
0 0         0         0         0         0 00000000 2 0 1008 0000
0 0         0         0         0         0 00000000 2 0 1009 0000
0 0         0         0         0         0 00000000 3 0 0000 1007
0 0         0         0         0         0 00000000 3 0 0000 100a
0 0         0         0         0         0 00000000 3 0 0000 0000
